//--- run_sim.sh
#!/bin/sh
# Build and run the tart_ctrl testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tart_ctrl_tb \
   -f tart_ctrl.f \
   -o Vtart_ctrl_tb

# The testbench stops with a non-zero status on failure, so the log decides.
./obj_dir/Vtart_ctrl_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
   echo "run_sim: testbench reported a failure"
   exit 1
fi
if ! grep -q "sim passed" sim.log; then
   echo "run_sim: testbench ended without a result"
   exit 1
fi
echo "run_sim: ok"

//--- source/ctrl_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

// bus front end.
// a strobe is taken whenever cyc and stb are high and no ack is out,
// so a held strobe is served every second cycle.
module ctrl_bus_decode (
   input  wire logic                 clk_i,
   input  wire logic                 rst_i,
   input  wire logic                 cyc_i,
   input  wire logic                 stb_i,
   input  wire logic                 we_i,
   input  wire ctrl_pkg::ctrl_addr_t adr_i,
   input  wire ctrl_pkg::ctrl_data_t dat_i,
   output ctrl_pkg::ctrl_req_t       req_o,
   output logic                      ack_o
);

   logic ack_q;    // registered acknowledge.
   logic accept;   // acceptance in this cycle.

   // the one place where a bus cycle is judged accepted.
   assign accept = cyc_i && stb_i && !ack_q;

   // ack follows an acceptance by one cycle and then drops again.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;   // never high twice in a row.
      end
   end

   assign ack_o = ack_q;

   // request for the execute and result stages.
   // the fields follow the bus, valid says whether they count.
   always_comb begin
      req_o.valid = accept;
      req_o.we    = we_i;
      req_o.addr  = adr_i;   // register select.
      req_o.data  = dat_i;   // write data.
   end

endmodule

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

   // bus geometry.
   localparam int DATA_W = 8;    // register and bus data width.
   localparam int ADDR_W = 2;    // four registers.

   typedef logic [DATA_W-1:0] ctrl_data_t;   // one bus data word.
   typedef logic [ADDR_W-1:0] ctrl_addr_t;   // one register address.

   // register map.
   localparam ctrl_addr_t ADDR_STATUS = 2'd0;   // live status input.
   localparam ctrl_addr_t ADDR_FLAGS  = 2'd1;   // pattern plus sticky fault bits.
   localparam ctrl_addr_t ADDR_MISC   = 2'd2;   // general read/write register.
   localparam ctrl_addr_t ADDR_RESET  = 2'd3;   // block id on read, reset on write.

   // fixed values.
   localparam ctrl_data_t MISC_RESET = 8'h3e;
   localparam ctrl_data_t ID_VALUE   = 8'h5c;   // identifies the control block.

   // upper six bits of the flags register never change.
   localparam logic [DATA_W-3:0] FLAGS_PATTERN = 6'b110011;

   // reset pulse length in clock cycles, and the counter that times it.
   localparam int RESET_CYCLES = 4;
   localparam int RESET_CNT_W  = $clog2(RESET_CYCLES + 1);

   // one accepted bus cycle, as seen by the execute and result stages.
   typedef struct packed {
      logic       valid;   // high in the cycle the strobe is accepted.
      logic       we;      // write when set.
      ctrl_addr_t addr;
      ctrl_data_t data;    // write data, ignored on reads.
   } ctrl_req_t;

   // execute-stage state that the read mux needs.
   typedef struct packed {
      ctrl_data_t misc;
      logic       overflow;   // sticky fifo overflow.
      logic       underrun;   // sticky fifo underrun.
   } ctrl_regs_t;

endpackage

`default_nettype wire

//--- source/ctrl_read_result.sv
`timescale 1ns/1ps
`default_nettype none

// read data path.
// the addressed value is sampled at the accepting edge and is held
// on dat_o until the next accepted read.
module ctrl_read_result (
   input  wire logic                 clk_i,
   input  wire logic                 rst_i,
   input  wire ctrl_pkg::ctrl_req_t  req_i,
   input  wire logic                 status_i,
   input  wire ctrl_pkg::ctrl_regs_t regs_i,
   output ctrl_pkg::ctrl_data_t      dat_o
);

   import ctrl_pkg::*;

   ctrl_data_t rd_mux;    // value for the addressed register.
   ctrl_data_t dat_q;
   logic       rd_en;     // accepted read.

   assign rd_en = req_i.valid && !req_i.we;

   // read multiplexer.
   always_comb begin
      case (req_i.addr)
         ADDR_STATUS: rd_mux = {{(DATA_W-1){1'b0}}, status_i};   // live input.
         ADDR_FLAGS:  rd_mux = {FLAGS_PATTERN, regs_i.overflow, regs_i.underrun};
         ADDR_MISC:   rd_mux = regs_i.misc;
         ADDR_RESET:  rd_mux = ID_VALUE;   // reads back the block id.
         default:     rd_mux = '0;
      endcase
   end

   // output register, writes leave it alone.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dat_q <= '0;
      end else if (rd_en) begin
         dat_q <= rd_mux;
      end
   end

   assign dat_o = dat_q;

endmodule

`default_nettype wire

//--- source/ctrl_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

// misc register and the sticky fault flags.
// the flags latch short fifo faults so that a slow poll still sees them.
module ctrl_reg_bank (
   input  wire logic                clk_i,
   input  wire logic                rst_i,
   input  wire ctrl_pkg::ctrl_req_t req_i,
   input  wire logic                overflow_i,
   input  wire logic                underrun_i,
   output ctrl_pkg::ctrl_regs_t     regs_o
);

   import ctrl_pkg::*;

   ctrl_data_t misc_q;      // misc register contents.
   logic       ovf_q;       // sticky overflow.
   logic       udf_q;       // sticky underrun.
   logic       wr_misc;     // accepted write to misc.
   logic       wr_flags;    // accepted write to flags.
   logic       clr_ovf;
   logic       clr_udf;

   // write strobes per register.
   assign wr_misc  = req_i.valid && req_i.we && (req_i.addr == ADDR_MISC);
   assign wr_flags = req_i.valid && req_i.we && (req_i.addr == ADDR_FLAGS);

   // write-one-to-clear, bit 1 is overflow and bit 0 underrun.
   assign clr_ovf = wr_flags && req_i.data[1];
   assign clr_udf = wr_flags && req_i.data[0];

   // misc register.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         misc_q <= MISC_RESET;
      end else if (wr_misc) begin
         misc_q <= req_i.data;   // whole byte is written.
      end
   end

   // sticky flags.
   // a fault in the same cycle as a clear keeps the bit set.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ovf_q <= 1'b0;
         udf_q <= 1'b0;
      end else begin
         ovf_q <= overflow_i || (ovf_q && !clr_ovf);
         udf_q <= underrun_i || (udf_q && !clr_udf);
      end
   end

   // state handed to the read mux.
   always_comb begin
      regs_o.misc     = misc_q;
      regs_o.overflow = ovf_q;
      regs_o.underrun = udf_q;
   end

endmodule

`default_nettype wire

//--- source/ctrl_reset_pulse.sv
`timescale 1ns/1ps
`default_nettype none

// system reset stretcher.
// downstream correlator logic gets a reset of guaranteed length,
// whether the request came from software or from the reset pin.
module ctrl_reset_pulse (
   input  wire logic                clk_i,
   input  wire logic                rst_i,
   input  wire ctrl_pkg::ctrl_req_t req_i,
   input  wire logic                reset_ni,
   output logic                     reset_o
);

   import ctrl_pkg::*;

   logic [RESET_CNT_W-1:0] cnt_q;    // cycles of pulse still to run.
   logic                   sw_trig;  // software reset request.
   logic                   cnt_busy;

   // a write to the reset register only fires with data bit 0 set.
   assign sw_trig = req_i.valid && req_i.we && (req_i.addr == ADDR_RESET)
                    && req_i.data[0];

   assign cnt_busy = (cnt_q != '0);

   // down-counter.
   // the trigger edge itself is the first pulse cycle, so software loads
   // one less than the pin, which starts counting on release.
   always_ff @(posedge clk_i) begin
      if (!reset_ni) begin
         cnt_q <= RESET_CNT_W'(RESET_CYCLES);   // pin holds the count full.
      end else if (rst_i) begin
         cnt_q <= '0;
      end else if (sw_trig) begin
         cnt_q <= RESET_CNT_W'(RESET_CYCLES - 1);   // a retrigger reloads.
      end else if (cnt_busy) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // registered pulse output.
   always_ff @(posedge clk_i) begin
      if (!reset_ni) begin
         reset_o <= 1'b1;   // external reset wins over everything.
      end else if (rst_i) begin
         reset_o <= 1'b0;
      end else begin
         reset_o <= sw_trig || cnt_busy;
      end
   end

endmodule

`default_nettype wire

//--- source/tart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// control register block of the correlator front end.
// bus decode, then register and reset execution, then read data.
module tart_ctrl (
   input  wire logic                 clk_i,
   input  wire logic                 rst_i,
   input  wire logic                 cyc_i,
   input  wire logic                 stb_i,
   input  wire logic                 we_i,
   input  wire ctrl_pkg::ctrl_addr_t adr_i,
   input  wire ctrl_pkg::ctrl_data_t dat_i,
   output logic                      ack_o,
   output ctrl_pkg::ctrl_data_t      dat_o,
   input  wire logic                 status_i,
   input  wire logic                 overflow_i,
   input  wire logic                 underrun_i,
   input  wire logic                 reset_ni,
   output logic                      reset_o
);

   import ctrl_pkg::*;

   ctrl_req_t  req;    // accepted bus cycle.
   ctrl_regs_t regs;   // register state for reads.

   // decode.
   ctrl_bus_decode u_decode (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cyc_i (cyc_i),
      .stb_i (stb_i),
      .we_i  (we_i),
      .adr_i (adr_i),
      .dat_i (dat_i),
      .req_o (req),
      .ack_o (ack_o)
   );

   // execute.
   ctrl_reg_bank u_regs (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (req),
      .overflow_i (overflow_i),
      .underrun_i (underrun_i),
      .regs_o     (regs)
   );

   ctrl_reset_pulse u_reset (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (req),
      .reset_ni (reset_ni),
      .reset_o  (reset_o)    // system reset to the correlator.
   );

   // result.
   ctrl_read_result u_result (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (req),
      .status_i (status_i),
      .regs_i   (regs),
      .dat_o    (dat_o)
   );

endmodule

`default_nettype wire

//--- tart_ctrl.f
source/ctrl_pkg.sv
source/ctrl_bus_decode.sv
source/ctrl_reg_bank.sv
source/ctrl_reset_pulse.sv
source/ctrl_read_result.sv
source/tart_ctrl.sv
verif/tart_ctrl_tb.sv

//--- verif/tart_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the control register block.
// seeded random bus traffic against a cycle model of the register rules.
module tart_ctrl_tb;

   import ctrl_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int N_RANDOM   = 400;   // random bus transactions.
   localparam int N_DIRECTED = 16;    // rough count of directed ones.
   localparam int TIMEOUT    = (N_RANDOM + N_DIRECTED) * 10 * CLK_PERIOD + 200 * CLK_PERIOD;

   logic       clk_i, rst_i;
   logic       cyc_i, stb_i, we_i;
   ctrl_addr_t adr_i;
   ctrl_data_t dat_i;
   logic       ack_o;
   ctrl_data_t dat_o;
   logic       status_i, overflow_i, underrun_i, reset_ni;
   logic       reset_o;

   // cycle model state.
   logic       m_ack, m_ovf, m_udf, m_reset;
   ctrl_data_t m_dat, m_misc;
   int         m_hold;      // edges that reset_o still stays high.

   string      test_name;
   logic       checking;    // model is valid once reset has been seen.
   logic       ext_en;      // random reset_ni low periods allowed.
   int         ext_low_left;
   logic       prev_ack;
   int         pulse_len;

   tart_ctrl u_dut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .ack_o      (ack_o),
      .dat_o      (dat_o),
      .status_i   (status_i),
      .overflow_i (overflow_i),
      .underrun_i (underrun_i),
      .reset_ni   (reset_ni),
      .reset_o    (reset_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // value a read of register a returns, from the current model state.
   function automatic ctrl_data_t expected_read(input ctrl_addr_t a);
      case (a)
         ADDR_STATUS: return {7'b0, status_i};
         ADDR_FLAGS:  return {FLAGS_PATTERN, m_ovf, m_udf};
         ADDR_MISC:   return m_misc;
         default:     return ID_VALUE;   // address 3.
      endcase
   endfunction

   // model steps on every rising edge, inputs are stable there.
   always @(posedge clk_i) begin : model
      logic accept;
      logic clr_ovf;
      logic clr_udf;
      accept  = cyc_i && stb_i && !m_ack;   // taken only while no ack is out.
      clr_ovf = accept && we_i && (adr_i == ADDR_FLAGS) && dat_i[1];
      clr_udf = accept && we_i && (adr_i == ADDR_FLAGS) && dat_i[0];
      if (rst_i) begin
         m_ack  = 1'b0;
         m_misc = MISC_RESET;
         m_ovf  = 1'b0;
         m_udf  = 1'b0;
         m_dat  = '0;
      end else begin
         if (accept && !we_i)
            m_dat = expected_read(adr_i);   // sampled before any update.
         if (accept && we_i && (adr_i == ADDR_MISC))
            m_misc = dat_i;
         m_ovf = overflow_i || (m_ovf && !clr_ovf);   // set beats clear.
         m_udf = underrun_i || (m_udf && !clr_udf);
         m_ack = accept;
      end
      if (!reset_ni) begin
         m_reset = 1'b1;                 // pin low, then a full pulse after release.
         m_hold  = RESET_CYCLES;
      end else if (rst_i) begin
         m_reset = 1'b0;
         m_hold  = 0;
      end else if (accept && we_i && (adr_i == ADDR_RESET) && dat_i[0]) begin
         m_reset = 1'b1;                 // trigger edge counts as the first cycle.
         m_hold  = RESET_CYCLES - 1;
      end else if (m_hold > 0) begin
         m_reset = 1'b1;
         m_hold  = m_hold - 1;
      end else begin
         m_reset = 1'b0;
      end
   end

   task automatic check_data(input string name, input ctrl_data_t exp, input ctrl_data_t act);
      if (act !== exp) begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("sim failed");
         $fatal(1, "data value mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
         $display("sim failed");
         $fatal(1, "control bit mismatch");
      end
   endtask

   // random status and fault levels, plus the occasional pin reset.
   task automatic drive_side();
      status_i   = 1'($urandom % 2);
      overflow_i = ($urandom % 10) == 0;
      underrun_i = ($urandom % 10) == 0;
      if (ext_low_left > 0) begin
         reset_ni = 1'b0;
         ext_low_left--;
      end else begin
         reset_ni = 1'b1;
         if (ext_en && ($urandom % 150) == 0)
            ext_low_left = 1 + int'($urandom % 5);
      end
   endtask

   // one clock, compare on the falling edge, then drive.
   task automatic step();
      @(negedge clk_i);
      if (checking) begin
         check_bit({test_name, ":ack"}, m_ack, ack_o);
         check_bit({test_name, ":ack_twice"}, 1'b0, prev_ack && ack_o);
         check_data({test_name, ":dat"}, m_dat, dat_o);
         check_bit({test_name, ":reset_o"}, m_reset, reset_o);
      end
      prev_ack = ack_o;
      drive_side();
   endtask

   // one bus cycle, waits for ack; with hold the strobe stays up for the next one.
   task automatic bus_cycle(input logic we, input ctrl_addr_t adr, input ctrl_data_t dat,
                            input logic hold);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = dat;
      step();
      while (ack_o !== 1'b1)
         step();
      if (!hold) begin
         cyc_i = 1'b0;
         stb_i = 1'b0;
      end
   endtask

   // watchdog.
   initial begin
      #(TIMEOUT);
      $display("watchdog: bus traffic did not finish in the allowed time");
      $display("sim failed");
      $fatal(1, "timeout");
   end

   initial begin : stimulus
      int   burst_left;
      logic hold;
      void'($urandom(32'h4a11));   // seeded once for the whole run.
      clk_i = 1'b0;
      rst_i = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      dat_i = '0;
      status_i   = 1'b0;
      overflow_i = 1'b0;
      underrun_i = 1'b0;
      reset_ni   = 1'b1;
      checking   = 1'b0;
      ext_en     = 1'b0;
      ext_low_left = 0;
      prev_ack   = 1'b0;
      burst_left = 0;
      test_name  = "reset_values";
      repeat (5) @(posedge clk_i);       // five reset edges.
      @(negedge clk_i);
      rst_i    = 1'b0;
      checking = 1'b1;
      check_bit("reset_values:ack", 1'b0, ack_o);
      check_bit("reset_values:reset_o", 1'b0, reset_o);
      check_data("reset_values:dat", 8'h00, dat_o);
      bus_cycle(1'b0, ADDR_MISC, 8'h00, 1'b0);
      check_data("reset_values:misc", MISC_RESET, dat_o);

      // software reset pulse, then a write with bit 0 clear.
      test_name = "soft_reset";
      bus_cycle(1'b1, ADDR_RESET, 8'h01, 1'b0);
      pulse_len = 0;
      while (reset_o === 1'b1) begin
         pulse_len++;
         step();
      end
      check_data("soft_reset:length", ctrl_data_t'(RESET_CYCLES), ctrl_data_t'(pulse_len));
      bus_cycle(1'b1, ADDR_RESET, 8'hfe, 1'b0);
      check_bit("soft_reset:no_pulse", 1'b0, reset_o);
      bus_cycle(1'b0, ADDR_RESET, 8'h00, 1'b0);
      check_data("soft_reset:id", ID_VALUE, dat_o);

      // pin reset, the model checks the stretched release.
      test_name    = "ext_reset";
      ext_low_left = 3;
      repeat (3 + RESET_CYCLES + 4) step();

      // random traffic with bursts on a held strobe.
      test_name = "random";
      ext_en    = 1'b1;
      for (int i = 0; i < N_RANDOM; i++) begin
         if (burst_left == 0 && ($urandom % 6) == 0)
            burst_left = 2 + int'($urandom % 4);
         hold = (burst_left > 1);
         if (burst_left > 0)
            burst_left--;
         bus_cycle(1'($urandom % 2), ctrl_addr_t'($urandom % 4), ctrl_data_t'($urandom), hold);
         if (!hold)
            repeat ($urandom % 4) step();
      end
      cyc_i  = 1'b0;
      stb_i  = 1'b0;
      ext_en = 1'b0;
      repeat (RESET_CYCLES + 12) step();   // let pulses and pin lows run out.

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire
